// ==== hdl/rob_pkg.sv ====
package rob_pkg;

    localparam int TAG_W     = 4;
    localparam int REG_W     = 5;
    localparam int XLEN      = 32;
    localparam int REG_COUNT = 32;

    // tag 0 is reserved, so one slot fewer than tags
    localparam int ROB_SLOTS = 15;
    localparam int COUNT_W   = $clog2(ROB_SLOTS + 1);

    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [REG_W-1:0]   reg_name_t;
    typedef logic [XLEN-1:0]    data_t;
    typedef logic [XLEN-1:0]    addr_t;
    typedef logic [COUNT_W-1:0] count_t;

    localparam tag_t NO_TAG    = tag_t'(0);
    localparam tag_t FIRST_TAG = tag_t'(1);
    localparam tag_t LAST_TAG  = tag_t'(ROB_SLOTS);

    // what the head entry turns into when it leaves
    typedef enum logic [1:0] {
        RET_NONE,
        RET_REG,
        RET_STORE,
        RET_FLUSH
    } retire_kind_t;

    // head and tail walk 1..15 and skip the null tag
    function automatic tag_t next_tag(input tag_t tag);
        tag_t nxt;
        if (tag == LAST_TAG) begin
            nxt = FIRST_TAG;
        end else begin
            nxt = tag + tag_t'(1);
        end
        return nxt;
    endfunction

endpackage

// ==== hdl/rob_alloc.sv ====
`timescale 1ns/1ps

module rob_alloc (
    input  logic          clk,
    input  logic          rst,
    input  logic          alloc_req,
    input  logic          retire_en,
    input  logic          flush,
    output logic          alloc_en,
    output rob_pkg::tag_t alloc_tag,
    output logic          full
);
    import rob_pkg::*;

    tag_t   tail;
    count_t count;

    assign full      = (count == count_t'(ROB_SLOTS));
    // no new tags while the buffer is being thrown away
    assign alloc_en  = alloc_req && !full && !flush;
    assign alloc_tag = tail;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            tail  <= FIRST_TAG;
            count <= '0;
        end else begin
            if (alloc_en) begin
                tail <= next_tag(tail);
            end
            case ({alloc_en, retire_en})
                2'b10:   count <= count + count_t'(1);
                2'b01:   count <= count - count_t'(1);
                default: count <= count;
            endcase
        end
    end

    // commit must not retire from an empty buffer
    a_no_underflow: assert property (
        @(posedge clk) disable iff (rst)
        retire_en |-> (count != '0)
    ) else $error("rob_alloc: retire with zero occupancy");

endmodule

// ==== hdl/rob_entries.sv ====
`timescale 1ns/1ps

module rob_entries (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    // dispatch
    input  logic               alloc_en,
    input  rob_pkg::tag_t      alloc_tag,
    input  rob_pkg::reg_name_t alloc_rd,
    input  logic               is_store,
    input  logic               pred_taken,
    // writeback
    input  logic               ex_en,
    input  rob_pkg::tag_t      ex_tag,
    input  rob_pkg::data_t     ex_data,
    input  logic               ex_taken,
    input  rob_pkg::addr_t     ex_target,
    input  logic               retire_en,
    // head view for commit
    output logic               head_valid,
    output logic               head_ready,
    output logic               head_store,
    output logic               head_mispredict,
    output rob_pkg::reg_name_t head_rd,
    output rob_pkg::data_t     head_data,
    output rob_pkg::addr_t     head_target,
    output rob_pkg::tag_t      head_tag
);
    import rob_pkg::*;

    // index 0 belongs to the null tag and is never filled
    logic [ROB_SLOTS:0] occupied;
    logic [ROB_SLOTS:0] ready;
    logic [ROB_SLOTS:0] store;
    logic [ROB_SLOTS:0] predicted;
    logic [ROB_SLOTS:0] actual;
    reg_name_t          entry_rd     [ROB_SLOTS:0];
    data_t              entry_data   [ROB_SLOTS:0];
    addr_t              entry_target [ROB_SLOTS:0];

    tag_t head;

    assign head_tag    = head;
    assign head_valid  = occupied[head];
    assign head_ready  = occupied[head] && ready[head];
    assign head_store  = store[head];
    assign head_rd     = entry_rd[head];
    assign head_data   = entry_data[head];
    assign head_target = entry_target[head];

    // stores carry no branch outcome
    assign head_mispredict = head_ready && !store[head] && (predicted[head] != actual[head]);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            occupied <= '0;
            ready    <= '0;
            head     <= FIRST_TAG;
        end else begin
            if (retire_en) begin
                occupied[head] <= 1'b0;
                ready[head]    <= 1'b0;
                head           <= next_tag(head);
            end
            if (alloc_en) begin
                occupied[alloc_tag] <= 1'b1;
                ready[alloc_tag]    <= 1'b0;
            end
            if (ex_en) begin
                ready[ex_tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            store[alloc_tag]     <= is_store;
            predicted[alloc_tag] <= pred_taken;
            entry_rd[alloc_tag]  <= alloc_rd;
        end
        if (ex_en) begin
            actual[ex_tag]       <= ex_taken;
            entry_data[ex_tag]   <= ex_data;
            entry_target[ex_tag] <= ex_target;
        end
    end

    // execute only reports on tags that dispatch handed out
    a_wb_occupied: assert property (
        @(posedge clk) disable iff (rst)
        ex_en |-> occupied[ex_tag]
    ) else $error("rob_entries: writeback to free tag %0d", ex_tag);

endmodule

// ==== hdl/commit_unit.sv ====
`timescale 1ns/1ps

module commit_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               head_valid,
    input  logic               head_ready,
    input  logic               head_store,
    input  logic               head_mispredict,
    input  rob_pkg::reg_name_t head_rd,
    input  rob_pkg::data_t     head_data,
    input  rob_pkg::addr_t     head_target,
    input  rob_pkg::tag_t      head_tag,
    output logic               retire_en,
    // register file write
    output logic               rf_en,
    output rob_pkg::reg_name_t rf_rd,
    output rob_pkg::data_t     rf_data,
    output rob_pkg::tag_t      rf_tag,
    // store release
    output logic               store_en,
    output rob_pkg::tag_t      store_tag,
    // redirect
    output logic               flush,
    output rob_pkg::addr_t     redirect_pc
);
    import rob_pkg::*;

    retire_kind_t kind;

    // hold off while the previous flush is still in flight
    assign retire_en = head_valid && head_ready && !flush;

    always_comb begin
        if (!retire_en) begin
            kind = RET_NONE;
        end else if (head_store) begin
            kind = RET_STORE;
        end else if (head_mispredict) begin
            kind = RET_FLUSH;
        end else begin
            kind = RET_REG;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rf_en    <= 1'b0;
            store_en <= 1'b0;
            flush    <= 1'b0;
        end else begin
            // a mispredicted branch still writes its link register
            rf_en    <= (kind == RET_REG) || (kind == RET_FLUSH);
            store_en <= (kind == RET_STORE);
            flush    <= (kind == RET_FLUSH);
        end
    end

    always_ff @(posedge clk) begin
        if ((kind == RET_REG) || (kind == RET_FLUSH)) begin
            rf_rd   <= head_rd;
            rf_data <= head_data;
            rf_tag  <= head_tag;
        end
        if (kind == RET_STORE) begin
            store_tag <= head_tag;
        end
        if (kind == RET_FLUSH) begin
            redirect_pc <= head_target;
        end
    end

endmodule

// ==== hdl/rename_table.sv ====
`timescale 1ns/1ps

module rename_table (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    // new mapping from dispatch
    input  logic               alloc_en,
    input  rob_pkg::reg_name_t alloc_rd,
    input  rob_pkg::tag_t      alloc_tag,
    // retire from commit
    input  logic               rf_en,
    input  rob_pkg::reg_name_t rf_rd,
    input  rob_pkg::tag_t      rf_tag,
    // source lookups
    input  rob_pkg::reg_name_t rs1,
    input  rob_pkg::reg_name_t rs2,
    output logic               rs1_busy,
    output rob_pkg::tag_t      rs1_tag,
    output logic               rs2_busy,
    output rob_pkg::tag_t      rs2_tag
);
    import rob_pkg::*;

    logic [REG_COUNT-1:0] busy;
    tag_t                 map_tag [REG_COUNT-1:0];

    logic map_write;
    logic map_release;

    // x0 is hardwired and never renamed
    assign map_write   = alloc_en && (alloc_rd != '0);
    // only the newest producer may free the mapping
    assign map_release = rf_en && busy[rf_rd] && (map_tag[rf_rd] == rf_tag);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy <= '0;
        end else begin
            if (map_release) begin
                busy[rf_rd] <= 1'b0;
            end
            // later write wins when both hit the same register
            if (map_write) begin
                busy[alloc_rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (map_write) begin
            map_tag[alloc_rd] <= alloc_tag;
        end
    end

    assign rs1_busy = busy[rs1];
    assign rs1_tag  = busy[rs1] ? map_tag[rs1] : NO_TAG;
    assign rs2_busy = busy[rs2];
    assign rs2_tag  = busy[rs2] ? map_tag[rs2] : NO_TAG;

endmodule

// ==== hdl/rob_top.sv ====
`timescale 1ns/1ps

module rob_top (
    input  logic               clk,
    input  logic               rst,
    // dispatch
    input  logic               alloc_req,
    input  rob_pkg::reg_name_t alloc_rd,
    input  logic               is_store,
    input  logic               pred_taken,
    output logic               alloc_en,
    output rob_pkg::tag_t      alloc_tag,
    output logic               full,
    // operand lookups
    input  rob_pkg::reg_name_t rs1,
    input  rob_pkg::reg_name_t rs2,
    output logic               rs1_busy,
    output rob_pkg::tag_t      rs1_tag,
    output logic               rs2_busy,
    output rob_pkg::tag_t      rs2_tag,
    // execute results
    input  logic               ex_en,
    input  rob_pkg::tag_t      ex_tag,
    input  rob_pkg::data_t     ex_data,
    input  logic               ex_taken,
    input  rob_pkg::addr_t     ex_target,
    // retire
    output logic               rf_en,
    output rob_pkg::reg_name_t rf_rd,
    output rob_pkg::data_t     rf_data,
    output rob_pkg::tag_t      rf_tag,
    output logic               store_en,
    output rob_pkg::tag_t      store_tag,
    output logic               flush,
    output rob_pkg::addr_t     redirect_pc
);
    import rob_pkg::*;

    logic      retire_en;
    logic      head_valid;
    logic      head_ready;
    logic      head_store;
    logic      head_mispredict;
    reg_name_t head_rd;
    data_t     head_data;
    addr_t     head_target;
    tag_t      head_tag;

    // all port names line up with the nets above
    rob_alloc    i_alloc   (.*);
    rob_entries  i_entries (.*);
    commit_unit  i_commit  (.*);
    rename_table i_rename  (.*);

endmodule

// ==== bench/rob_tb.sv ====
`timescale 1ns/1ps

module rob_tb;
    import rob_pkg::*;

    localparam int MAX_ROWS = 80;

    typedef enum logic [1:0] {
        OP_IDLE,
        OP_ALLOC,
        OP_WB
    } op_t;

    // one clock cycle of stimulus and the outputs expected in it
    typedef struct packed {
        op_t       op;
        reg_name_t rd;
        logic      is_store;
        logic      pred_taken;
        tag_t      ex_tag;
        data_t     ex_data;
        logic      ex_taken;
        addr_t     ex_target;
        reg_name_t rs;
        logic      exp_alloc_en;
        tag_t      exp_alloc_tag;
        logic      exp_full;
        logic      exp_rf_en;
        reg_name_t exp_rf_rd;
        data_t     exp_rf_data;
        tag_t      exp_rf_tag;
        logic      exp_store_en;
        tag_t      exp_store_tag;
        logic      exp_flush;
        addr_t     exp_redirect;
        logic      exp_busy;
        tag_t      exp_rs_tag;
    } row_t;

    logic      clk;
    logic      rst;
    logic      alloc_req;
    reg_name_t alloc_rd;
    logic      is_store;
    logic      pred_taken;
    logic      alloc_en;
    tag_t      alloc_tag;
    logic      full;
    reg_name_t rs1;
    reg_name_t rs2;
    logic      rs1_busy;
    tag_t      rs1_tag;
    logic      rs2_busy;
    tag_t      rs2_tag;
    logic      ex_en;
    tag_t      ex_tag;
    data_t     ex_data;
    logic      ex_taken;
    addr_t     ex_target;
    logic      rf_en;
    reg_name_t rf_rd;
    data_t     rf_data;
    tag_t      rf_tag;
    logic      store_en;
    tag_t      store_tag;
    logic      flush;
    addr_t     redirect_pc;

    row_t      rows      [0:MAX_ROWS-1];
    string     row_names [0:MAX_ROWS-1];
    data_t     wb_data   [0:15];
    int        n_rows;
    int        errors;
    integer    seed;
    bit        built;
    string     cur_name;
    logic      full_state;
    reg_name_t look_reg;
    logic      look_busy;
    tag_t      look_tag;

    rob_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .alloc_req   (alloc_req),
        .alloc_rd    (alloc_rd),
        .is_store    (is_store),
        .pred_taken  (pred_taken),
        .alloc_en    (alloc_en),
        .alloc_tag   (alloc_tag),
        .full        (full),
        .rs1         (rs1),
        .rs2         (rs2),
        .rs1_busy    (rs1_busy),
        .rs1_tag     (rs1_tag),
        .rs2_busy    (rs2_busy),
        .rs2_tag     (rs2_tag),
        .ex_en       (ex_en),
        .ex_tag      (ex_tag),
        .ex_data     (ex_data),
        .ex_taken    (ex_taken),
        .ex_target   (ex_target),
        .rf_en       (rf_en),
        .rf_rd       (rf_rd),
        .rf_data     (rf_data),
        .rf_tag      (rf_tag),
        .store_en    (store_en),
        .store_tag   (store_tag),
        .flush       (flush),
        .redirect_pc (redirect_pc)
    );

    task automatic add_row(input string name, input op_t op);
        rows[n_rows]            = '0;
        rows[n_rows].op         = op;
        rows[n_rows].exp_full   = full_state;
        rows[n_rows].rs         = look_reg;
        rows[n_rows].exp_busy   = look_busy;
        rows[n_rows].exp_rs_tag = look_tag;
        row_names[n_rows]       = name;
        n_rows++;
    endtask

    task automatic add_alloc(input string name, input reg_name_t rd, input logic st,
                             input logic pt, input logic en, input tag_t tag);
        add_row(name, OP_ALLOC);
        rows[n_rows-1].rd            = rd;
        rows[n_rows-1].is_store      = st;
        rows[n_rows-1].pred_taken    = pt;
        rows[n_rows-1].exp_alloc_en  = en;
        rows[n_rows-1].exp_alloc_tag = tag;
    endtask

    task automatic add_wb(input string name, input tag_t tag, input logic taken,
                          input addr_t target);
        add_row(name, OP_WB);
        wb_data[tag]             = $random(seed);
        rows[n_rows-1].ex_tag    = tag;
        rows[n_rows-1].ex_data   = wb_data[tag];
        rows[n_rows-1].ex_taken  = taken;
        rows[n_rows-1].ex_target = target;
    endtask

    task automatic add_idle(input string name);
        add_row(name, OP_IDLE);
    endtask

    task automatic expect_rf(input reg_name_t rd, input tag_t tag);
        rows[n_rows-1].exp_rf_en   = 1'b1;
        rows[n_rows-1].exp_rf_rd   = rd;
        rows[n_rows-1].exp_rf_data = wb_data[tag];
        rows[n_rows-1].exp_rf_tag  = tag;
    endtask

    task automatic expect_store(input tag_t tag);
        rows[n_rows-1].exp_store_en  = 1'b1;
        rows[n_rows-1].exp_store_tag = tag;
    endtask

    task automatic expect_flush(input addr_t pc);
        rows[n_rows-1].exp_flush    = 1'b1;
        rows[n_rows-1].exp_redirect = pc;
    endtask

    task automatic set_lookup(input reg_name_t r, input logic busy, input tag_t tag);
        look_reg  = r;
        look_busy = busy;
        look_tag  = tag;
    endtask

    task automatic build_table();
        int i;
        // results return out of order but retire in order
        add_idle("reset_state");
        add_alloc("alloc_t1", 5, 0, 0, 1, 1);
        add_alloc("alloc_t2", 6, 0, 0, 1, 2);
        add_alloc("alloc_t3", 7, 0, 0, 1, 3);
        add_alloc("alloc_t4", 8, 0, 0, 1, 4);
        add_wb("wb_t4", 4, 0, '0);
        add_wb("wb_t3", 3, 0, '0);
        add_wb("wb_t2", 2, 0, '0);
        add_wb("wb_t1", 1, 0, '0);
        add_idle("head_ready_t1");
        add_idle("retire_t1");
        expect_rf(5, 1);
        add_idle("retire_t2");
        expect_rf(6, 2);
        add_idle("retire_t3");
        expect_rf(7, 3);
        add_idle("retire_t4");
        expect_rf(8, 4);

        add_alloc("alloc_store_t5", 0, 1, 0, 1, 5);
        add_wb("wb_store_t5", 5, 0, '0);
        add_idle("store_head_ready");
        add_idle("store_release");
        expect_store(5);

        // branch predicted not-taken that resolves taken
        add_alloc("alloc_branch_t6", 1, 0, 0, 1, 6);
        add_alloc("alloc_young_t7", 10, 0, 0, 1, 7);
        add_alloc("alloc_young_t8", 11, 0, 0, 1, 8);
        add_wb("wb_young_t7", 7, 0, '0);
        add_wb("wb_branch_t6", 6, 1, 32'h0000_2040);
        add_idle("branch_head_ready");
        add_alloc("flush_blocks_alloc", 12, 0, 0, 0, '0);
        expect_rf(1, 6);
        expect_flush(32'h0000_2040);

        // allocation restarts at tag 1 after the flush
        for (i = 1; i <= ROB_SLOTS; i++) begin
            add_alloc($sformatf("fill_t%0d", i), 9, 0, 0, 1, tag_t'(i));
        end
        full_state = 1'b1;
        add_alloc("alloc_while_full", 9, 0, 0, 0, '0);
        add_wb("wb_fill_t1", 1, 0, '0);
        add_idle("fill_head_ready");
        full_state = 1'b0;
        add_alloc("alloc_after_wrap", 9, 0, 0, 1, 1);
        expect_rf(9, 1);
        full_state = 1'b1;
        add_idle("full_again");
        add_wb("wb_mispredict_t2", 2, 1, 32'h0000_3000);
        add_idle("mispredict_head_ready");
        full_state = 1'b0;
        add_idle("flush_full_buffer");
        expect_rf(9, 2);
        expect_flush(32'h0000_3000);
        add_idle("empty_after_flush");

        // same-cycle allocation is not yet visible to the lookup
        set_lookup(3, 0, '0);
        add_alloc("rename_alloc_t1", 3, 0, 0, 1, 1);
        set_lookup(3, 1, 1);
        add_alloc("rename_alloc_t2", 3, 0, 0, 1, 2);
        set_lookup(3, 1, 2);
        add_idle("rename_newest");
        add_wb("rename_wb_t1", 1, 0, '0);
        add_idle("rename_ready_t1");
        add_idle("rename_retire_t1");
        expect_rf(3, 1);
        add_wb("rename_wb_t2", 2, 0, '0);
        add_idle("rename_ready_t2");
        add_idle("rename_retire_t2");
        expect_rf(3, 2);
        set_lookup(3, 0, '0);
        add_idle("rename_released");
        set_lookup(0, 0, '0);
        add_alloc("alloc_x0", 0, 0, 0, 1, 3);
        add_idle("x0_not_busy");
    endtask

    task automatic drive_row(input row_t r);
        alloc_req  <= (r.op == OP_ALLOC);
        alloc_rd   <= r.rd;
        is_store   <= r.is_store;
        pred_taken <= r.pred_taken;
        ex_en      <= (r.op == OP_WB);
        ex_tag     <= r.ex_tag;
        ex_data    <= r.ex_data;
        ex_taken   <= r.ex_taken;
        ex_target  <= r.ex_target;
        rs1        <= r.rs;
        rs2        <= r.rs;
    endtask

    task automatic compare_field(input string field, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("** Error %s: %s expected 0x%0h actual 0x%0h",
                     cur_name, field, exp, act);
        end
    endtask

    task automatic check_row(input row_t r);
        compare_field("alloc_en", r.exp_alloc_en, alloc_en);
        if (r.exp_alloc_en) begin
            compare_field("alloc_tag", r.exp_alloc_tag, alloc_tag);
        end
        compare_field("full", r.exp_full, full);
        compare_field("rf_en", r.exp_rf_en, rf_en);
        if (r.exp_rf_en) begin
            compare_field("rf_rd", r.exp_rf_rd, rf_rd);
            compare_field("rf_data", r.exp_rf_data, rf_data);
            compare_field("rf_tag", r.exp_rf_tag, rf_tag);
        end
        compare_field("store_en", r.exp_store_en, store_en);
        if (r.exp_store_en) begin
            compare_field("store_tag", r.exp_store_tag, store_tag);
        end
        compare_field("flush", r.exp_flush, flush);
        if (r.exp_flush) begin
            compare_field("redirect_pc", r.exp_redirect, redirect_pc);
        end
        compare_field("rs1_busy", r.exp_busy, rs1_busy);
        compare_field("rs2_busy", r.exp_busy, rs2_busy);
        if (r.exp_busy) begin
            compare_field("rs1_tag", r.exp_rs_tag, rs1_tag);
            compare_field("rs2_tag", r.exp_rs_tag, rs2_tag);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        wait (built);
        #(n_rows * 8 * 4);
        $display("watchdog expired after %0d ns with the table unfinished", n_rows * 32);
        $display("Test failed");
        $finish;
    end

    initial begin
        int r;
        rst        = 1'b1;
        alloc_req  = 1'b0;
        alloc_rd   = '0;
        is_store   = 1'b0;
        pred_taken = 1'b0;
        ex_en      = 1'b0;
        ex_tag     = '0;
        ex_data    = '0;
        ex_taken   = 1'b0;
        ex_target  = '0;
        rs1        = '0;
        rs2        = '0;
        errors     = 0;
        n_rows     = 0;
        seed       = 88;
        built      = 1'b0;
        full_state = 1'b0;
        set_lookup(0, 0, '0);
        build_table();
        built = 1'b1;

        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // drive on the rising edge and sample at the falling edge
        for (r = 0; r < n_rows; r++) begin
            @(posedge clk);
            drive_row(rows[r]);
            @(negedge clk);
            cur_name = row_names[r];
            check_row(rows[r]);
        end

        $display("%0d errors over %0d rows", errors, n_rows);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
hdl/rob_pkg.sv
hdl/rob_alloc.sv
hdl/rob_entries.sv
hdl/commit_unit.sv
hdl/rename_table.sv
hdl/rob_top.sv
bench/rob_tb.sv
